// File: project.f
+incdir+tb
source/mem_bus_pkg.sv
source/refill_csr_pkg.sv
source/refill_csr.sv
source/refill_issue.sv
source/return_buffer.sv
source/l1_refill_top.sv
tb/tb_l1_refill.sv

// File: source/l1_refill_top.sv
`timescale 1ns/1ps
// l1 refill path: register block, burst issuer and return buffer for one outstanding miss
module l1_refill_top #(
    parameter int offset_width = 2
) (
    input  logic                                                  clk,
    input  logic                                                  rstn,
    input  logic                                                  cache_mem_req,
    input  logic [mem_bus_pkg::addr_width-1:0]                    cache_addr,
    output logic                                                  cache_req_ready,
    output logic                                                  mem_cache_dataOK,
    output logic [(1<<offset_width)*mem_bus_pkg::beat_width-1:0]  din_mem_cache,
    output logic                                                  arvalid,
    input  logic                                                  arready,
    output logic [mem_bus_pkg::addr_width-1:0]                    araddr,
    output logic [mem_bus_pkg::len_width-1:0]                     arlen,
    input  logic                                                  rvalid,
    output logic                                                  rready,
    input  logic [mem_bus_pkg::beat_width-1:0]                    rdata,
    input  logic                                                  rlast,
    input  logic                                                  s_awvalid,
    output logic                                                  s_awready,
    input  logic [refill_csr_pkg::csr_addr_width-1:0]             s_awaddr,
    input  logic                                                  s_wvalid,
    output logic                                                  s_wready,
    input  logic [refill_csr_pkg::csr_data_width-1:0]             s_wdata,
    output logic                                                  s_bvalid,
    input  logic                                                  s_bready,
    output logic [1:0]                                            s_bresp,
    input  logic                                                  s_arvalid,
    output logic                                                  s_arready,
    input  logic [refill_csr_pkg::csr_addr_width-1:0]             s_araddr,
    output logic                                                  s_rvalid,
    input  logic                                                  s_rready,
    output logic [refill_csr_pkg::csr_data_width-1:0]             s_rdata,
    output logic [1:0]                                            s_rresp
);

    logic                               refill_enable;
    logic                               burst_active;
    logic                               line_done;
    logic                               len_error;
    logic                               fill_start;
    logic [mem_bus_pkg::addr_width-1:0] fill_addr;

    refill_csr refill_csr_i (
        .clk, .rstn,
        .s_awvalid, .s_awready, .s_awaddr,
        .s_wvalid, .s_wready, .s_wdata,
        .s_bvalid, .s_bready, .s_bresp,
        .s_arvalid, .s_arready, .s_araddr,
        .s_rvalid, .s_rready, .s_rdata, .s_rresp,
        .fill_start, .fill_addr, .line_done, .len_error, .burst_active,
        .refill_enable
    );

    refill_issue #(.offset_width(offset_width)) refill_issue_i (
        .clk, .rstn, .refill_enable,
        .cache_mem_req, .cache_addr, .cache_req_ready,
        .arvalid, .arready, .araddr, .arlen,
        .line_done, .burst_active, .fill_start, .fill_addr
    );

    return_buffer #(.offset_width(offset_width)) return_buffer_i (
        .clk, .rstn, .burst_active,
        .rvalid, .rdata, .rlast, .rready,
        .mem_cache_dataOK, .din_mem_cache,
        .line_done, .len_error
    );

    dataok_single: assert property (@(posedge clk) disable iff (!rstn)
        mem_cache_dataOK |=> !mem_cache_dataOK);

    // a new miss is only offered once the buffer has drained.
    ready_when_drained: assert property (@(posedge clk) disable iff (!rstn)
        cache_req_ready |-> return_buffer_i.state == mem_bus_pkg::refill_idle);

endmodule

// File: source/mem_bus_pkg.sv
// memory bus definitions: read channel widths, burst length rule and refill fsm states
package mem_bus_pkg;

    localparam int addr_width      = 32;
    localparam int beat_width      = 32;
    localparam int len_width       = 8;   // axi arlen field.
    localparam int beat_bytes_log2 = 2;   // byte offset inside one beat.

    // return buffer states.
    typedef enum logic [1:0] {
        refill_idle,
        refill_receive,
        refill_send
    } refill_state_t;

    // issuer states.
    typedef enum logic [1:0] {
        issue_idle,
        issue_addr,
        issue_wait
    } issue_state_t;

    // one burst per line, arlen is beats minus one.
    function automatic logic [len_width-1:0] burst_len(int offset_width);
        return len_width'((1 << offset_width) - 1);
    endfunction

endpackage

// File: source/refill_csr.sv
`timescale 1ns/1ps
// refill register block: axi4-lite slave for enable, refill count, last address and error status
module refill_csr (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      s_awvalid,
    output logic                                      s_awready,
    input  logic [refill_csr_pkg::csr_addr_width-1:0] s_awaddr,
    input  logic                                      s_wvalid,
    output logic                                      s_wready,
    input  logic [refill_csr_pkg::csr_data_width-1:0] s_wdata,
    output logic                                      s_bvalid,
    input  logic                                      s_bready,
    output logic [1:0]                                s_bresp,
    input  logic                                      s_arvalid,
    output logic                                      s_arready,
    input  logic [refill_csr_pkg::csr_addr_width-1:0] s_araddr,
    output logic                                      s_rvalid,
    input  logic                                      s_rready,
    output logic [refill_csr_pkg::csr_data_width-1:0] s_rdata,
    output logic [1:0]                                s_rresp,
    input  logic                                      fill_start,
    input  logic [mem_bus_pkg::addr_width-1:0]        fill_addr,
    input  logic                                      line_done,
    input  logic                                      len_error,
    input  logic                                      burst_active,
    output logic                                      refill_enable
);

    logic                                      wr_en;
    logic                                      err_sticky;
    logic [refill_csr_pkg::csr_data_width-1:0] refill_count;
    logic [mem_bus_pkg::addr_width-1:0]        last_addr;
    logic [refill_csr_pkg::csr_data_width-1:0] rd_word;
    refill_csr_pkg::csr_sel_t                  wr_sel;
    refill_csr_pkg::csr_sel_t                  rd_sel;

    assign wr_en     = s_awvalid && s_wvalid && !s_bvalid;  // address and data taken together.
    assign s_awready = wr_en;
    assign s_wready  = wr_en;
    assign s_arready = !s_rvalid;
    assign s_bresp   = 2'b00;  // okay.
    assign s_rresp   = 2'b00;
    assign wr_sel    = refill_csr_pkg::csr_decode(s_awaddr);
    assign rd_sel    = refill_csr_pkg::csr_decode(s_araddr);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s_bvalid <= 1'b0;
        end else if (wr_en) begin
            s_bvalid <= 1'b1;
        end else if (s_bready) begin
            s_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            refill_enable <= 1'b0;
        end else if (wr_en && wr_sel == refill_csr_pkg::sel_ctrl) begin
            refill_enable <= s_wdata[refill_csr_pkg::ctrl_enable_bit];
        end
    end

    // a new error wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            err_sticky <= 1'b0;
        end else if (line_done && len_error) begin
            err_sticky <= 1'b1;
        end else if (wr_en && wr_sel == refill_csr_pkg::sel_status &&
                     s_wdata[refill_csr_pkg::status_len_error_bit]) begin
            err_sticky <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            refill_count <= '0;
            last_addr    <= '0;
        end else begin
            if (line_done) begin
                refill_count <= refill_count + 1'b1;
            end
            if (fill_start) begin
                last_addr <= fill_addr;  // already line aligned.
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (rd_sel)
            refill_csr_pkg::sel_ctrl: begin
                rd_word[refill_csr_pkg::ctrl_enable_bit] = refill_enable;
            end
            refill_csr_pkg::sel_status: begin
                rd_word[refill_csr_pkg::status_busy_bit]      = burst_active;
                rd_word[refill_csr_pkg::status_len_error_bit] = err_sticky;
            end
            refill_csr_pkg::sel_count:     rd_word = refill_count;
            refill_csr_pkg::sel_last_addr: rd_word = last_addr;
            default:                       rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s_rvalid <= 1'b0;
        end else if (s_arvalid && s_arready) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) begin
            s_rdata <= rd_word;  // sampled at address accept.
        end
    end

    bvalid_held: assert property (@(posedge clk) disable iff (!rstn)
        s_bvalid && !s_bready |=> s_bvalid);

endmodule

// File: source/refill_csr_pkg.sv
// refill register map: register offsets, selector decode and control bit positions
package refill_csr_pkg;

    localparam int csr_addr_width = 4;
    localparam int csr_data_width = 32;

    localparam logic [csr_addr_width-1:0] ctrl_offset      = 4'h0;
    localparam logic [csr_addr_width-1:0] status_offset    = 4'h4;
    localparam logic [csr_addr_width-1:0] count_offset     = 4'h8;
    localparam logic [csr_addr_width-1:0] last_addr_offset = 4'hc;

    typedef enum logic [1:0] {
        sel_ctrl,
        sel_status,
        sel_count,
        sel_last_addr
    } csr_sel_t;

    localparam int ctrl_enable_bit      = 0;
    localparam int status_busy_bit      = 0;
    localparam int status_len_error_bit = 1;   // sticky, write 1 to clear.

    // byte lanes inside a word are ignored.
    function automatic csr_sel_t csr_decode(logic [csr_addr_width-1:0] offset);
        case ({offset[csr_addr_width-1:2], 2'b00})
            ctrl_offset:      return sel_ctrl;
            status_offset:    return sel_status;
            count_offset:     return sel_count;
            last_addr_offset: return sel_last_addr;
            default:          return sel_ctrl;
        endcase
    endfunction

endpackage

// File: source/refill_issue.sv
`timescale 1ns/1ps
// refill issuer: takes one cache miss at a time and sends a line-aligned read burst
module refill_issue #(
    parameter int offset_width = 2
) (
    input  logic                                 clk,
    input  logic                                 rstn,
    input  logic                                 refill_enable,
    input  logic                                 cache_mem_req,
    input  logic [mem_bus_pkg::addr_width-1:0]   cache_addr,
    output logic                                 cache_req_ready,
    output logic                                 arvalid,
    input  logic                                 arready,
    output logic [mem_bus_pkg::addr_width-1:0]   araddr,
    output logic [mem_bus_pkg::len_width-1:0]    arlen,
    input  logic                                 line_done,
    output logic                                 burst_active,
    output logic                                 fill_start,
    output logic [mem_bus_pkg::addr_width-1:0]   fill_addr
);

    localparam int line_lsb = offset_width + mem_bus_pkg::beat_bytes_log2;

    mem_bus_pkg::issue_state_t state;
    logic                      accept;

    assign cache_req_ready = refill_enable && (state == mem_bus_pkg::issue_idle);
    assign accept          = cache_mem_req && cache_req_ready;
    assign arvalid         = (state == mem_bus_pkg::issue_addr);
    assign arlen           = mem_bus_pkg::burst_len(offset_width);
    assign burst_active    = (state != mem_bus_pkg::issue_idle);
    assign fill_addr       = araddr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= mem_bus_pkg::issue_idle;
        end else begin
            case (state)
                mem_bus_pkg::issue_idle: begin
                    if (accept) state <= mem_bus_pkg::issue_addr;
                end
                mem_bus_pkg::issue_addr: begin
                    if (arready) state <= mem_bus_pkg::issue_wait;
                end
                mem_bus_pkg::issue_wait: begin
                    if (line_done) state <= mem_bus_pkg::issue_idle;  // beats all returned.
                end
                default: state <= mem_bus_pkg::issue_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            araddr <= {cache_addr[mem_bus_pkg::addr_width-1:line_lsb], {line_lsb{1'b0}}};
        end
    end

    // pulses with the first arvalid cycle.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fill_start <= 1'b0;
        end else begin
            fill_start <= accept;
        end
    end

    araddr_held: assert property (@(posedge clk) disable iff (!rstn)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// File: source/return_buffer.sv
`timescale 1ns/1ps
// return buffer: gathers read beats into one cache line and checks the burst length
module return_buffer #(
    parameter int offset_width = 2
) (
    input  logic                                                  clk,
    input  logic                                                  rstn,
    input  logic                                                  burst_active,
    input  logic                                                  rvalid,
    input  logic [mem_bus_pkg::beat_width-1:0]                    rdata,
    input  logic                                                  rlast,
    output logic                                                  rready,
    output logic                                                  mem_cache_dataOK,
    output logic [(1<<offset_width)*mem_bus_pkg::beat_width-1:0]  din_mem_cache,
    output logic                                                  line_done,
    output logic                                                  len_error
);

    localparam int words      = 1 << offset_width;
    localparam int line_width = words * mem_bus_pkg::beat_width;
    localparam int cnt_width  = offset_width + 2;  // room for overlong bursts.

    mem_bus_pkg::refill_state_t state;
    logic                       beat_ok;
    logic [cnt_width-1:0]       beat_cnt;
    logic [cnt_width-1:0]       beat_total;
    logic                       len_bad;

    assign rready           = burst_active && (state != mem_bus_pkg::refill_send);
    assign beat_ok          = rvalid && rready;
    assign beat_total       = (state == mem_bus_pkg::refill_idle) ? cnt_width'(1)
                                                                  : beat_cnt + 1'b1;
    assign mem_cache_dataOK = (state == mem_bus_pkg::refill_send);
    assign line_done        = mem_cache_dataOK;
    assign len_error        = line_done && len_bad;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= mem_bus_pkg::refill_idle;
        end else begin
            case (state)
                mem_bus_pkg::refill_idle, mem_bus_pkg::refill_receive: begin
                    if (beat_ok) begin
                        state <= rlast ? mem_bus_pkg::refill_send
                                       : mem_bus_pkg::refill_receive;
                    end
                end
                default: state <= mem_bus_pkg::refill_idle;  // send lasts one cycle.
            endcase
        end
    end

    // first beat ends up in the top word.
    always_ff @(posedge clk) begin
        if (beat_ok) begin
            din_mem_cache <= {din_mem_cache[line_width-mem_bus_pkg::beat_width-1:0], rdata};
            beat_cnt      <= beat_total;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_ok && rlast) begin
            len_bad <= (beat_total != cnt_width'(words));
        end
    end

endmodule

// File: tb/refill_tb_tasks.svh
// refill testbench helpers: axi4-lite register access and the expected cache line model
`ifndef refill_tb_tasks_svh
`define refill_tb_tasks_svh

task automatic csr_write(input logic [refill_csr_pkg::csr_addr_width-1:0] offset,
                         input logic [31:0] data);
    int   n;
    logic taken;
    @(posedge clk);
    s_awvalid <= 1'b1;
    s_awaddr  <= offset;
    s_wvalid  <= 1'b1;
    s_wdata   <= data;
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!(s_awready && s_wready) && n < wait_limit);
    taken = s_awready && s_wready;
    s_awvalid <= 1'b0;
    s_wvalid  <= 1'b0;
    if (!taken) begin
        $display("timeout at %0t ns waiting for the register write handshake", $time);
        timeout_count++;
    end else begin
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_bvalid && n < wait_limit);  // bready is held high.
        if (!s_bvalid) begin
            $display("timeout at %0t ns waiting for s_bvalid", $time);
            timeout_count++;
        end else if (s_bresp !== 2'b00) begin
            $display("Error at %0t ns: s_bresp = %b, expected %b", $time, s_bresp, 2'b00);
            error_count++;
        end
    end
endtask

task automatic csr_read(input logic [refill_csr_pkg::csr_addr_width-1:0] offset,
                        output logic [31:0] data);
    int   n;
    logic taken;
    data = 'x;
    @(posedge clk);
    s_arvalid <= 1'b1;
    s_araddr  <= offset;
    n = 0;
    do begin
        @(posedge clk);
        n++;
    end while (!s_arready && n < wait_limit);
    taken = s_arready;
    s_arvalid <= 1'b0;
    if (!taken) begin
        $display("timeout at %0t ns waiting for s_arready", $time);
        timeout_count++;
    end else begin
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!s_rvalid && n < wait_limit);
        if (!s_rvalid) begin
            $display("timeout at %0t ns waiting for s_rvalid", $time);
            timeout_count++;
        end else begin
            data = s_rdata;
            if (s_rresp !== 2'b00) begin
                $display("Error at %0t ns: s_rresp = %b, expected %b", $time, s_rresp,
                         2'b00);
                error_count++;
            end
        end
    end
endtask

// beat k of a line is base xor k*0x01010101, the first beat lands in the top word
function automatic logic [line_width-1:0] ref_line(input logic [31:0] base);
    logic [line_width-1:0] line;
    int                    k;
    line = '0;
    for (k = 0; k < words; k++) begin
        line = (line << 32) | line_width'(base ^ (k * 32'h0101_0101));
    end
    return line;
endfunction

`endif

// File: tb/tb_l1_refill.sv
`timescale 1ns/1ps
// l1 refill testbench: random-stall memory responder, register accesses and line checker
module tb_l1_refill;

    localparam int offset_width = 2;
    localparam int words        = 1 << offset_width;
    localparam int line_width   = words * 32;
    localparam int line_bytes   = words * 4;
    localparam int wait_limit   = 400;
    localparam int refill_runs  = 16;

    logic                                      clk = 1'b0;
    logic                                      rstn;
    logic                                      cache_mem_req;
    logic [31:0]                               cache_addr;
    logic                                      cache_req_ready;
    logic                                      mem_cache_dataOK;
    logic [line_width-1:0]                     din_mem_cache;
    logic                                      arvalid;
    logic                                      arready = 1'b0;
    logic [31:0]                               araddr;
    logic [mem_bus_pkg::len_width-1:0]         arlen;
    logic                                      rvalid = 1'b0;
    logic                                      rready;
    logic [31:0]                               rdata = '0;
    logic                                      rlast = 1'b0;
    logic                                      s_awvalid;
    logic                                      s_awready;
    logic [refill_csr_pkg::csr_addr_width-1:0] s_awaddr;
    logic                                      s_wvalid;
    logic                                      s_wready;
    logic [31:0]                               s_wdata;
    logic                                      s_bvalid;
    logic                                      s_bready;
    logic [1:0]                                s_bresp;
    logic                                      s_arvalid;
    logic                                      s_arready;
    logic [refill_csr_pkg::csr_addr_width-1:0] s_araddr;
    logic                                      s_rvalid;
    logic                                      s_rready;
    logic [31:0]                               s_rdata;
    logic [1:0]                                s_rresp;

    int                    error_count;
    int                    timeout_count;
    int                    done_count;
    int                    req_count;
    int                    run;
    int                    hold_n;
    logic                  cut_short;
    logic [31:0]           exp_addr_q[$];
    logic                  exp_short_q[$];
    logic [line_width-1:0] exp_line;
    logic [31:0]           rd_word;
    logic [31:0]           miss_addr;
    logic [31:0]           last_aligned;
    logic                  burst_open;
    logic [31:0]           burst_base;
    int                    beat_idx;
    int                    beat_total;

    `include "refill_tb_tasks.svh"

    l1_refill_top #(.offset_width(offset_width)) l1_refill_top_i (.*);

    always #10 clk = ~clk;

    // one burst at a time, arready and rvalid stall at random.
    always @(posedge clk) begin
        if (!rstn) begin
            arready    <= 1'b0;
            rvalid     <= 1'b0;
            rlast      <= 1'b0;
            rdata      <= '0;
            burst_open = 1'b0;
        end else begin
            if (arvalid && arready) begin
                burst_base = araddr;
                beat_idx   = 0;
                beat_total = arlen + 1 - (cut_short ? 1 : 0);  // early rlast when cut short.
                burst_open = 1'b1;
            end
            if (rvalid && rready) begin
                beat_idx = beat_idx + 1;
                if (rlast) begin
                    burst_open = 1'b0;
                end
            end
            arready <= ($urandom % 4) != 0;
            if (!burst_open) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end else if (!rvalid || rready) begin  // a pending beat is held until taken.
                rvalid <= ($urandom % 3) != 0;
                rdata  <= burst_base ^ (beat_idx * 32'h0101_0101);
                rlast  <= (beat_idx == beat_total - 1);
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && arvalid && arready) begin
            if (exp_addr_q.size() == 0) begin
                $display("read burst issued at %0t ns without an accepted miss", $time);
                error_count++;
            end else if (araddr !== exp_addr_q[0]) begin
                $display("Error at %0t ns: araddr = %h, expected %h", $time, araddr,
                         exp_addr_q[0]);
                error_count++;
            end
            if (arlen != words - 1) begin
                $display("Error at %0t ns: arlen = %0d, expected %0d", $time, arlen, words - 1);
                error_count++;
            end
        end
        if (rstn && mem_cache_dataOK) begin
            done_count++;
            if (exp_addr_q.size() == 0) begin
                $display("mem_cache_dataOK at %0t ns without an outstanding miss", $time);
                error_count++;
            end else begin
                exp_line = ref_line(exp_addr_q[0]);
                if (!exp_short_q[0] && din_mem_cache !== exp_line) begin
                    $display("Error at %0t ns: din_mem_cache = %h, expected %h", $time,
                             din_mem_cache, exp_line);
                    error_count++;
                end
                void'(exp_addr_q.pop_front());
                void'(exp_short_q.pop_front());
            end
        end
    end

    task automatic refill_line(input logic [31:0] addr, input logic short_burst);
        int n;
        cut_short = short_burst;
        @(posedge clk);
        cache_mem_req <= 1'b1;
        cache_addr    <= addr;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!cache_req_ready && n < wait_limit);
        cache_mem_req <= 1'b0;
        if (!cache_req_ready) begin
            $display("timeout at %0t ns waiting for cache_req_ready", $time);
            timeout_count++;
        end else begin
            exp_addr_q.push_back(addr & ~32'(line_bytes - 1));
            exp_short_q.push_back(short_burst);
            req_count++;
            n = 0;
            do begin
                @(posedge clk);
                n++;
            end while (!mem_cache_dataOK && n < wait_limit);
            if (!mem_cache_dataOK) begin
                $display("timeout at %0t ns waiting for mem_cache_dataOK", $time);
                timeout_count++;
            end
        end
        cut_short = 1'b0;
    endtask

    initial begin
        void'($urandom(80966));
        error_count   = 0;
        timeout_count = 0;
        done_count    = 0;
        req_count     = 0;
        cut_short     = 1'b0;
        last_aligned  = '0;
        rstn          <= 1'b0;
        cache_mem_req <= 1'b0;
        cache_addr    <= '0;
        s_awvalid     <= 1'b0;
        s_awaddr      <= '0;
        s_wvalid      <= 1'b0;
        s_wdata       <= '0;
        s_bready      <= 1'b1;
        s_arvalid     <= 1'b0;
        s_araddr      <= '0;
        s_rready      <= 1'b1;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        if (cache_req_ready !== 1'b0) begin
            $display("Error at %0t ns: cache_req_ready = %b, expected 0", $time,
                     cache_req_ready);
            error_count++;
        end
        csr_read(refill_csr_pkg::status_offset, rd_word);
        if (rd_word !== 32'h0) begin
            $display("Error at %0t ns: status = %h, expected %h", $time, rd_word, 32'h0);
            error_count++;
        end
        csr_write(refill_csr_pkg::ctrl_offset, 32'(1) << refill_csr_pkg::ctrl_enable_bit);
        hold_n = 0;
        while (!cache_req_ready && hold_n < wait_limit) begin
            @(posedge clk);
            hold_n++;
        end
        if (!cache_req_ready) begin
            $display("timeout at %0t ns, cache_req_ready stayed low after enable", $time);
            timeout_count++;
        end

        for (run = 0; run < refill_runs; run++) begin
            miss_addr = $urandom;
            refill_line(miss_addr, 1'b0);
            last_aligned = miss_addr & ~32'(line_bytes - 1);
        end
        csr_read(refill_csr_pkg::count_offset, rd_word);
        if (rd_word !== 32'(req_count)) begin
            $display("Error at %0t ns: count = %0d, expected %0d", $time, rd_word, req_count);
            error_count++;
        end
        csr_read(refill_csr_pkg::last_addr_offset, rd_word);
        if (rd_word !== last_aligned) begin
            $display("Error at %0t ns: last_addr = %h, expected %h", $time, rd_word,
                     last_aligned);
            error_count++;
        end

        // burst with rlast one beat early.
        refill_line($urandom, 1'b1);
        csr_read(refill_csr_pkg::status_offset, rd_word);
        if (rd_word[refill_csr_pkg::status_len_error_bit] !== 1'b1) begin
            $display("Error at %0t ns: status len_error bit = %b, expected %b", $time,
                     rd_word[refill_csr_pkg::status_len_error_bit], 1'b1);
            error_count++;
        end
        csr_write(refill_csr_pkg::status_offset,
                  32'(1) << refill_csr_pkg::status_len_error_bit);
        csr_read(refill_csr_pkg::status_offset, rd_word);
        if (rd_word !== 32'h0) begin
            $display("Error at %0t ns: status = %h, expected %h", $time, rd_word, 32'h0);
            error_count++;
        end

        csr_write(refill_csr_pkg::ctrl_offset, 32'h0);
        @(posedge clk);
        cache_mem_req <= 1'b1;
        cache_addr    <= $urandom;
        hold_n = 0;
        while (!arvalid && hold_n < wait_limit) begin
            @(posedge clk);
            hold_n++;
        end
        cache_mem_req <= 1'b0;
        if (arvalid) begin
            $display("arvalid rose at %0t ns while refills were disabled", $time);
            error_count++;
        end
        if (done_count != req_count) begin
            $display("Error at %0t ns: mem_cache_dataOK pulses = %0d, expected %0d", $time,
                     done_count, req_count);
            error_count++;
        end

        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
